/* async_fifo_asym.f */
design/fifo_pkg.sv
design/gray_counter.sv
design/cdc_gray_sync.sv
design/fifo_write_ctrl.sv
design/fifo_read_ctrl.sv
design/asym_dual_port_ram.sv
design/async_fifo_asym.sv
dv/async_fifo_asym_props.sv
dv/async_fifo_asym_tb.sv

/* design/asym_dual_port_ram.sv */
`timescale 1ns/1ns

module asym_dual_port_ram (
   // write port, whole words
   input  logic                          w_clk_i,
   input  logic                          we_i,
   input  logic [fifo_pkg::W_ADDR_W-1:0] waddr_i,
   input  fifo_pkg::w_data_t             w_data_i,

   // read port, one lane per access
   input  logic                          r_clk_i,
   input  logic                          reset_i,
   input  logic                          re_i,
   input  logic [fifo_pkg::R_ADDR_W-1:0] raddr_i,
   output fifo_pkg::r_data_t             r_data_o
);

   import fifo_pkg::*;

   fifo_word_u          mem [W_WORDS];
   logic [W_ADDR_W-1:0] rd_word;
   logic [RATIO_W-1:0]  rd_lane;
   r_data_t             r_data_q;

   // upper lane address bits select the word, low bits the byte
   assign rd_word = raddr_i[R_ADDR_W-1:RATIO_W];
   assign rd_lane = raddr_i[RATIO_W-1:0];

   always_ff @(posedge w_clk_i) begin
      if (we_i) begin
         mem[waddr_i].word <= w_data_i;
      end
   end

   // read register holds its lane until the next accepted read
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         r_data_q <= '0;
      end else if (re_i) begin
         r_data_q <= mem[rd_word].lane[rd_lane];
      end
   end

   assign r_data_o = r_data_q;

endmodule

/* design/async_fifo_asym.sv */
`timescale 1ns/1ns

module async_fifo_asym (
   input  logic              w_clk_i,
   input  logic              r_clk_i,
   input  logic              reset_i,

   // write side
   input  logic              w_en_i,
   input  fifo_pkg::w_data_t w_data_i,
   output fifo_pkg::level_t  w_level_o,
   output logic              w_full_o,
   output logic              w_empty_o,

   // read side
   input  logic              r_en_i,
   output fifo_pkg::r_data_t r_data_o,
   output fifo_pkg::level_t  r_level_o,
   output logic              r_full_o,
   output logic              r_empty_o
);

   import fifo_pkg::*;

   // pointers, local gray and synchronized binary
   w_ptr_t w_ptr_gray;
   w_ptr_t r_w_ptr_bin;
   r_ptr_t r_ptr_gray;
   r_ptr_t w_r_ptr_bin;

   // storage control
   logic                ram_we;
   logic [W_ADDR_W-1:0] ram_waddr;
   logic                ram_re;
   logic [R_ADDR_W-1:0] ram_raddr;

   fifo_write_ctrl u_write_ctrl (
      .w_clk_i      (w_clk_i),
      .reset_i      (reset_i),
      .w_en_i       (w_en_i),
      .r_ptr_bin_i  (w_r_ptr_bin),
      .w_ptr_gray_o (w_ptr_gray),
      .ram_we_o     (ram_we),
      .ram_waddr_o  (ram_waddr),
      .w_level_o    (w_level_o),
      .w_full_o     (w_full_o),
      .w_empty_o    (w_empty_o)
   );

   // write pointer into the read domain
   cdc_gray_sync #(
      .WIDTH (W_ADDR_W + 1)
   ) u_w_ptr_sync (
      .clk_i   (r_clk_i),
      .reset_i (reset_i),
      .gray_i  (w_ptr_gray),
      .bin_o   (r_w_ptr_bin)
   );

   fifo_read_ctrl u_read_ctrl (
      .r_clk_i      (r_clk_i),
      .reset_i      (reset_i),
      .r_en_i       (r_en_i),
      .w_ptr_bin_i  (r_w_ptr_bin),
      .r_ptr_gray_o (r_ptr_gray),
      .ram_re_o     (ram_re),
      .ram_raddr_o  (ram_raddr),
      .r_level_o    (r_level_o),
      .r_full_o     (r_full_o),
      .r_empty_o    (r_empty_o)
   );

   // read pointer into the write domain
   cdc_gray_sync #(
      .WIDTH (R_ADDR_W + 1)
   ) u_r_ptr_sync (
      .clk_i   (w_clk_i),
      .reset_i (reset_i),
      .gray_i  (r_ptr_gray),
      .bin_o   (w_r_ptr_bin)
   );

   asym_dual_port_ram u_ram (
      .w_clk_i  (w_clk_i),
      .we_i     (ram_we),
      .waddr_i  (ram_waddr),
      .w_data_i (w_data_i),
      .r_clk_i  (r_clk_i),
      .reset_i  (reset_i),
      .re_i     (ram_re),
      .raddr_i  (ram_raddr),
      .r_data_o (r_data_o)
   );

endmodule

/* design/cdc_gray_sync.sv */
`timescale 1ns/1ns

module cdc_gray_sync #(
   parameter int WIDTH = 3
) (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic [WIDTH-1:0] gray_i,
   output logic [WIDTH-1:0] bin_o
);

   // two destination flops in series
   logic [WIDTH-1:0] meta_q;
   logic [WIDTH-1:0] sync_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= gray_i;
         sync_q <= meta_q;
      end
   end

   // gray to binary, each bit is the xor of itself and all bits above
   always_comb begin
      for (int i = 0; i < WIDTH; i++) begin
         bin_o[i] = ^(sync_q >> i);
      end
   end

endmodule

/* design/fifo_pkg.sv */
package fifo_pkg;

   // write side carries whole words, read side single byte lanes
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // lanes per word, lane 0 is the least significant byte
   localparam int RATIO   = W_DATA_W / R_DATA_W;
   localparam int RATIO_W = $clog2(RATIO);

   // addressing is counted in narrow lanes
   localparam int ADDR_W     = 4;
   localparam int W_ADDR_W   = ADDR_W - RATIO_W;
   localparam int R_ADDR_W   = ADDR_W;
   localparam int FIFO_LANES = 1 << ADDR_W;
   localparam int W_WORDS    = FIFO_LANES / RATIO;

   typedef logic [W_DATA_W-1:0] w_data_t;
   typedef logic [R_DATA_W-1:0] r_data_t;

   // one extra bit so a completely full FIFO reads as 16
   typedef logic [ADDR_W:0] level_t;

   // pointers carry the wrap bit above the address
   typedef logic [W_ADDR_W:0] w_ptr_t;
   typedef logic [R_ADDR_W:0] r_ptr_t;

   // stored word, seen whole by the write port and lane by lane by the read port
   typedef union packed {
      w_data_t                 word;
      r_data_t [RATIO-1:0]     lane;
   } fifo_word_u;

   // full once fewer than one word of lanes is free
   localparam level_t FULL_LIMIT = level_t'(FIFO_LANES - RATIO);

   // one word expressed as a lane count
   localparam level_t WORD_LANES = level_t'(RATIO);

endpackage

/* design/fifo_read_ctrl.sv */
`timescale 1ns/1ns

module fifo_read_ctrl (
   input  logic                          r_clk_i,
   input  logic                          reset_i,
   input  logic                          r_en_i,
   input  fifo_pkg::w_ptr_t              w_ptr_bin_i,
   output fifo_pkg::r_ptr_t              r_ptr_gray_o,
   output logic                          ram_re_o,
   output logic [fifo_pkg::R_ADDR_W-1:0] ram_raddr_o,
   output fifo_pkg::level_t              r_level_o,
   output logic                          r_full_o,
   output logic                          r_empty_o
);

   import fifo_pkg::*;

   r_ptr_t r_ptr_bin;
   level_t w_ptr_lanes;
   level_t level;
   logic   r_accept;

   // reads are ignored while nothing is stored
   assign r_accept = r_en_i & ~r_empty_o;

   gray_counter #(
      .WIDTH (R_ADDR_W + 1)
   ) u_r_ptr (
      .clk_i   (r_clk_i),
      .reset_i (reset_i),
      .en_i    (r_accept),
      .bin_o   (r_ptr_bin),
      .gray_o  (r_ptr_gray_o)
   );

   // synchronized word pointer brought to lane units
   assign w_ptr_lanes = {w_ptr_bin_i, {RATIO_W{1'b0}}};

   assign level = w_ptr_lanes - level_t'(r_ptr_bin);

   // same threshold as the write side
   assign r_full_o = (level > FULL_LIMIT);

   // a single stored lane is enough to read
   assign r_empty_o = (level == '0);

   assign r_level_o = level;

   // lane address, low bits pick the byte within the word
   assign ram_re_o    = r_accept;
   assign ram_raddr_o = r_ptr_bin[R_ADDR_W-1:0];

endmodule

/* design/fifo_write_ctrl.sv */
`timescale 1ns/1ns

module fifo_write_ctrl (
   input  logic                          w_clk_i,
   input  logic                          reset_i,
   input  logic                          w_en_i,
   input  fifo_pkg::r_ptr_t              r_ptr_bin_i,
   output fifo_pkg::w_ptr_t              w_ptr_gray_o,
   output logic                          ram_we_o,
   output logic [fifo_pkg::W_ADDR_W-1:0] ram_waddr_o,
   output fifo_pkg::level_t              w_level_o,
   output logic                          w_full_o,
   output logic                          w_empty_o
);

   import fifo_pkg::*;

   w_ptr_t w_ptr_bin;
   level_t w_ptr_lanes;
   level_t level;
   logic   w_accept;

   // a write while full is simply dropped
   assign w_accept = w_en_i & ~w_full_o;

   gray_counter #(
      .WIDTH (W_ADDR_W + 1)
   ) u_w_ptr (
      .clk_i   (w_clk_i),
      .reset_i (reset_i),
      .en_i    (w_accept),
      .bin_o   (w_ptr_bin),
      .gray_o  (w_ptr_gray_o)
   );

   // each word advances the lane count by RATIO
   assign w_ptr_lanes = {w_ptr_bin, {RATIO_W{1'b0}}};

   // modular difference, pointer wrap bits keep 0..16 unambiguous
   assign level = w_ptr_lanes - level_t'(r_ptr_bin_i);

   // room for a whole word is needed before the next write
   assign w_full_o = (level > FULL_LIMIT);

   // less than one word stored, as seen from this side
   assign w_empty_o = (level < WORD_LANES);

   assign w_level_o = level;

   assign ram_we_o    = w_accept;
   assign ram_waddr_o = w_ptr_bin[W_ADDR_W-1:0];

endmodule

/* design/gray_counter.sv */
`timescale 1ns/1ns

module gray_counter #(
   parameter int WIDTH = 3
) (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             en_i,
   output logic [WIDTH-1:0] bin_o,
   output logic [WIDTH-1:0] gray_o
);

   logic [WIDTH-1:0] bin_q;
   logic [WIDTH-1:0] gray_q;
   logic [WIDTH-1:0] bin_next;

   assign bin_next = bin_q + WIDTH'(1);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (en_i) begin
         bin_q  <= bin_next;
         // registered gray copy, only one bit flips per step
         gray_q <= bin_next ^ (bin_next >> 1);
      end
   end

   // binary stays local, gray goes across the domain boundary
   assign bin_o  = bin_q;
   assign gray_o = gray_q;

endmodule

/* dv/async_fifo_asym_patterns.txt */
# columns: operation, one hex argument (ignored by reset, empty and drain)
# read gives the expected lane, settle the level in lanes, random the step count
reset 0
write a1b2c3d4
settle 4
read d4
read c3
read b2
read a1
settle 0
empty 0
write 03020100
write 07060504
write 0b0a0908
write 0f0e0d0c
settle 10
write deadbeef
read 00
drain 0
settle 0
random 30
drain 0
settle 0
write 11223344
reset 0
settle 0

/* dv/async_fifo_asym_props.sv */
`timescale 1ns/1ns

module async_fifo_asym_props (
   input logic              w_clk_i,
   input logic              r_clk_i,
   input logic              reset_i,
   input logic              w_en_i,
   input logic              r_en_i,
   input fifo_pkg::w_ptr_t  w_ptr_gray_i,
   input fifo_pkg::r_ptr_t  r_ptr_gray_i,
   input logic              w_full_i,
   input logic              r_empty_i,
   input fifo_pkg::level_t  w_level_i,
   input fifo_pkg::level_t  r_level_i,
   input fifo_pkg::r_data_t r_data_i
);

   import fifo_pkg::*;

   // a write attempt against a full FIFO leaves the write pointer in place
   write_not_full: assert property (@(posedge w_clk_i) disable iff (reset_i)
      (w_en_i && w_full_i) |=> $stable(w_ptr_gray_i))
      else $error("write pointer moved while w_full_o was high");

   read_not_empty: assert property (@(posedge r_clk_i) disable iff (reset_i)
      (r_en_i && r_empty_i) |=> $stable(r_ptr_gray_i))
      else $error("read pointer moved while r_empty_o was high");

   // output lane only moves on an accepted read
   data_hold: assert property (@(posedge r_clk_i) disable iff (reset_i)
      !(r_en_i && !r_empty_i) |=> $stable(r_data_i))
      else $error("r_data_o changed without an accepted read");

   // neither side may count more lanes than the storage holds
   w_level_bound: assert property (@(posedge w_clk_i) disable iff (reset_i)
      w_level_i <= level_t'(FIFO_LANES))
      else $error("w_level_o above the FIFO capacity");

   r_level_bound: assert property (@(posedge r_clk_i) disable iff (reset_i)
      r_level_i <= level_t'(FIFO_LANES))
      else $error("r_level_o above the FIFO capacity");

endmodule

bind async_fifo_asym async_fifo_asym_props u_props (
   .w_clk_i      (w_clk_i),
   .r_clk_i      (r_clk_i),
   .reset_i      (reset_i),
   .w_en_i       (w_en_i),
   .r_en_i       (r_en_i),
   .w_ptr_gray_i (w_ptr_gray),
   .r_ptr_gray_i (r_ptr_gray),
   .w_full_i     (w_full_o),
   .r_empty_i    (r_empty_o),
   .w_level_i    (w_level_o),
   .r_level_i    (r_level_o),
   .r_data_i     (r_data_o)
);

/* dv/async_fifo_asym_tb.sv */
`timescale 1ns/1ns

module async_fifo_asym_tb;

   import fifo_pkg::*;

   localparam int          W_HALF       = 2;
   localparam int          R_HALF       = 3;
   localparam int          RESET_CYCLES = 16;
   localparam int          W_WAIT_MAX   = 15;
   localparam int          R_WAIT_MAX   = 10;
   localparam int          NS_PER_LINE  = 40 * 2 * R_HALF;
   localparam int          FULL_LANES   = FIFO_LANES - RATIO;
   localparam logic [31:0] LCG_SEED     = 32'd64;
   localparam string       PATTERN_FILE = "dv/async_fifo_asym_patterns.txt";

   logic    w_clk_i;
   logic    r_clk_i;
   logic    reset_i;
   logic    w_en_i;
   w_data_t w_data_i;
   logic    r_en_i;
   r_data_t r_data_o;
   level_t  w_level_o;
   logic    w_full_o;
   logic    w_empty_o;
   level_t  r_level_o;
   logic    r_full_o;
   logic    r_empty_o;

   // reference model holds one entry per byte lane
   r_data_t     model_q[$];
   r_data_t     last_lane;
   logic [31:0] lcg_state;
   longint      wd_limit_ns;
   logic        wd_armed;

   async_fifo_asym dut (
      .w_clk_i   (w_clk_i),
      .r_clk_i   (r_clk_i),
      .reset_i   (reset_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_level_o (w_level_o),
      .w_full_o  (w_full_o),
      .w_empty_o (w_empty_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_level_o (r_level_o),
      .r_full_o  (r_full_o),
      .r_empty_o (r_empty_o)
   );

   always begin
      #W_HALF w_clk_i = ~w_clk_i;
   end

   // 6 ns read clock with no relation to the 4 ns write clock
   always begin
      #R_HALF r_clk_i = ~r_clk_i;
   end

   task automatic stop_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic fail_plain(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   task automatic check_lane(input string name, input r_data_t exp, input r_data_t act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_level(input string name, input level_t exp, input level_t act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         stop_run();
      end
   endtask

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic apply_reset();
      @(negedge w_clk_i);
      reset_i = 1'b1;
      w_en_i  = 1'b0;
      repeat (RESET_CYCLES) @(negedge w_clk_i);
      reset_i = 1'b0;
      model_q.delete();
      last_lane = '0;
      @(negedge w_clk_i);
      check_level("w_level_o", '0, w_level_o);
      check_flag("w_full_o", 1'b0, w_full_o);
      check_flag("w_empty_o", 1'b1, w_empty_o);
      @(negedge r_clk_i);
      check_level("r_level_o", '0, r_level_o);
      check_flag("r_full_o", 1'b0, r_full_o);
      check_flag("r_empty_o", 1'b1, r_empty_o);
      check_lane("r_data_o", '0, r_data_o);
   endtask

   // lane 0 is the least significant byte and leaves first
   task automatic write_word(input w_data_t data, input logic respect_full);
      @(negedge w_clk_i);
      if (!w_full_o || !respect_full) begin
         if (!w_full_o) begin
            for (int l = 0; l < RATIO; l++) begin
               model_q.push_back(data[l*R_DATA_W +: R_DATA_W]);
            end
         end
         w_en_i   = 1'b1;
         w_data_i = data;
         @(negedge w_clk_i);
         w_en_i = 1'b0;
      end
   endtask

   task automatic read_checked(input logic has_exp, input r_data_t file_exp);
      int      waited;
      r_data_t exp;
      waited = 0;
      @(negedge r_clk_i);
      while (r_empty_o && waited < R_WAIT_MAX) begin
         @(negedge r_clk_i);
         waited++;
      end
      if (r_empty_o) begin
         fail_plain("read timed out because r_empty_o stayed high");
      end
      if (model_q.size() == 0) begin
         fail_plain("DUT offers data while the reference model is empty");
      end
      exp = model_q.pop_front();
      if (has_exp && exp != file_exp) begin
         fail_plain("pattern file and reference model disagree on the next lane");
      end
      r_en_i = 1'b1;
      @(negedge r_clk_i);
      r_en_i = 1'b0;
      check_lane("r_data_o", exp, r_data_o);
      last_lane = exp;
   endtask

   // nothing may change when reading an empty FIFO
   task automatic read_while_empty();
      @(negedge r_clk_i);
      check_flag("r_empty_o", model_q.size() == 0, r_empty_o);
      r_en_i = 1'b1;
      @(negedge r_clk_i);
      r_en_i = 1'b0;
      check_lane("r_data_o", last_lane, r_data_o);
      check_level("r_level_o", level_t'(model_q.size()), r_level_o);
      @(negedge w_clk_i);
      check_level("w_level_o", level_t'(model_q.size()), w_level_o);
   endtask

   // pointers need two to three cycles to cross, so poll with a bound
   task automatic settle_levels(input level_t exp_level);
      level_t want;
      int     n;
      want = level_t'(model_q.size());
      if (want != exp_level) begin
         fail_plain("pattern level does not match the reference model");
      end
      n = 0;
      @(negedge w_clk_i);
      while (w_level_o != want && n < W_WAIT_MAX) begin
         @(negedge w_clk_i);
         n++;
      end
      check_level("w_level_o", want, w_level_o);
      check_flag("w_full_o", want > FULL_LANES, w_full_o);
      check_flag("w_empty_o", want < RATIO, w_empty_o);
      n = 0;
      @(negedge r_clk_i);
      while (r_level_o != want && n < R_WAIT_MAX) begin
         @(negedge r_clk_i);
         n++;
      end
      check_level("r_level_o", want, r_level_o);
      check_flag("r_full_o", want > FULL_LANES, r_full_o);
      check_flag("r_empty_o", want == 0, r_empty_o);
   endtask

   // every level on the way down passes through the flag thresholds
   task automatic drain_checked();
      while (model_q.size() > 0) begin
         read_checked(1'b0, '0);
         settle_levels(level_t'(model_q.size()));
      end
   endtask

   // about one step in four writes a word of four lanes
   task automatic random_block(input int steps);
      for (int i = 0; i < steps; i++) begin
         lcg_state = lcg_step(lcg_state);
         if (lcg_state[31:30] == 2'b00) begin
            lcg_state = lcg_step(lcg_state);
            write_word(lcg_state, 1'b1);
         end else begin
            @(negedge r_clk_i);
            if (!r_empty_o) begin
               read_checked(1'b0, '0);
            end
         end
      end
   endtask

   task automatic run_op(input logic [63:0] op, input logic [31:0] arg);
      case (op)
         "reset":  apply_reset();
         "write":  write_word(arg, 1'b0);
         "read":   read_checked(1'b1, arg[R_DATA_W-1:0]);
         "settle": settle_levels(level_t'(arg));
         "empty":  read_while_empty();
         "random": random_block(int'(arg));
         "drain":  drain_checked();
         default:  fail_plain("unknown operation in the pattern file");
      endcase
   endtask

   initial begin
      int               fd;
      int               code;
      int               n_lines;
      logic [63:0]      op;
      logic [8*120-1:0] line;
      logic [31:0]      arg;

      w_clk_i     = 1'b0;
      r_clk_i     = 1'b0;
      reset_i     = 1'b1;
      w_en_i      = 1'b0;
      w_data_i    = '0;
      r_en_i      = 1'b0;
      last_lane   = '0;
      lcg_state   = LCG_SEED;
      wd_armed    = 1'b0;
      wd_limit_ns = 0;

      // first pass only sizes the watchdog
      n_lines = 0;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         fail_plain("cannot open the pattern file");
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 0) begin
            n_lines++;
         end
      end
      $fclose(fd);
      wd_limit_ns = n_lines * NS_PER_LINE + RESET_CYCLES * 2 * W_HALF;
      wd_armed    = 1'b1;

      fd = $fopen(PATTERN_FILE, "r");
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", op);
         if (code == 1) begin
            if (op == "#") begin
               code = $fgets(line, fd);
            end else begin
               code = $fscanf(fd, "%h", arg);
               if (code != 1) begin
                  fail_plain("pattern line has no argument");
               end
               run_op(op, arg);
            end
         end
      end
      $fclose(fd);
      $display("All tests passed");
      $finish;
   end

   initial begin
      wait (wd_armed === 1'b1);
      #(wd_limit_ns);
      $display("timeout, the pattern run did not finish within %0d ns", wd_limit_ns);
      stop_run();
   end

endmodule
